/* logic/pad_cfg_cell.sv */
`timescale 1ns/1ps
`default_nettype none
`include "padctl_defines.svh"

module pad_cfg_cell #(
    parameter padctl_pkg::pad_ctrl_t DEFAULT_CFG = `PADCTL_DEF_INPUT
) (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire                   serial_clock_i,
    input  wire                   serial_load_n_i,
    input  wire                   shift_in_i,
    output logic                  shift_out_o,
    output padctl_pkg::pad_ctrl_t cfg_o
);

    logic                   clock_q;
    logic                   load_n_q;
    logic                   clock_rise;
    logic                   load_fall;
    padctl_pkg::pad_ctrl_t  stage_q;

    // Serial bus edges seen in the clk domain
    assign clock_rise = serial_clock_i & ~clock_q;
    assign load_fall  = ~serial_load_n_i & load_n_q;

    // Low after reset so the loader's held-low load is not taken as an edge
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            clock_q  <= 1'b0;
            load_n_q <= 1'b0;
        end else begin
            clock_q  <= serial_clock_i;
            load_n_q <= serial_load_n_i;
        end
    end

    always_ff @(posedge clk) begin
        if (clock_rise) begin
            stage_q <= {stage_q[`PADCTL_CTRL_BITS-2:0], shift_in_i};
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cfg_o <= DEFAULT_CFG;
        end else if (load_fall) begin
            cfg_o <= stage_q;
        end
    end

    assign shift_out_o = stage_q[`PADCTL_CTRL_BITS-1];

endmodule

`default_nettype wire

/* logic/pad_serial_loader.sv */
`timescale 1ns/1ps
`default_nettype none
`include "padctl_defines.svh"

module pad_serial_loader (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire padctl_pkg::pad_cfg_arr_t pad_cfg_i,
    input  wire                           xfer_start_i,
    output logic                          busy_o,
    output padctl_pkg::serial_bus_t       serial_o
);

    localparam int IDX_W = $clog2(`PADCTL_NUM_PADS);
    localparam int CNT_W = $clog2(`PADCTL_CTRL_BITS);
    localparam logic [IDX_W-1:0] CHAIN1_FIRST = IDX_W'(`PADCTL_CHAIN_PADS - 1);
    localparam logic [IDX_W-1:0] CHAIN2_FIRST = IDX_W'(`PADCTL_CHAIN_PADS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`PADCTL_CTRL_BITS - 1);

    padctl_pkg::loader_state_e  state_q;
    logic [CNT_W-1:0]           xfer_count;
    logic [IDX_W-1:0]           pad_count_1;
    logic [IDX_W-1:0]           pad_count_2;
    logic                       serial_clock_q;
    logic                       serial_resetn_q;
    padctl_pkg::pad_ctrl_t      staging_1;
    padctl_pkg::pad_ctrl_t      staging_2;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q         <= padctl_pkg::LDR_IDLE;
            xfer_count      <= '0;
            pad_count_1     <= CHAIN1_FIRST;
            pad_count_2     <= CHAIN2_FIRST;
            serial_clock_q  <= 1'b0;
            serial_resetn_q <= 1'b0;
            staging_1       <= '0;
            staging_2       <= '0;
        end else begin
            case (state_q)
                padctl_pkg::LDR_IDLE: begin
                    pad_count_1     <= CHAIN1_FIRST;
                    pad_count_2     <= CHAIN2_FIRST;
                    serial_clock_q  <= 1'b0;
                    serial_resetn_q <= 1'b1;
                    if (xfer_start_i) begin
                        state_q <= padctl_pkg::LDR_START;
                    end
                end
                padctl_pkg::LDR_START: begin
                    serial_clock_q <= 1'b0;
                    xfer_count     <= '0;
                    staging_1      <= pad_cfg_i[pad_count_1];
                    staging_2      <= pad_cfg_i[pad_count_2];
                    state_q        <= padctl_pkg::LDR_XBYTE;
                end
                padctl_pkg::LDR_XBYTE: begin
                    if (!serial_clock_q) begin
                        serial_clock_q <= 1'b1;
                    end else begin
                        // Next bit goes out on the falling half
                        staging_1 <= {staging_1[`PADCTL_CTRL_BITS-2:0], 1'b0};
                        staging_2 <= {staging_2[`PADCTL_CTRL_BITS-2:0], 1'b0};
                        if (xfer_count == LAST_BIT) begin
                            xfer_count <= '0;
                            if (pad_count_1 == '0) begin
                                // Clock stays high into the load sequence
                                state_q <= padctl_pkg::LDR_LOAD;
                            end else begin
                                serial_clock_q <= 1'b0;
                                pad_count_1    <= pad_count_1 - 1'b1;
                                pad_count_2    <= pad_count_2 + 1'b1;
                                state_q        <= padctl_pkg::LDR_START;
                            end
                        end else begin
                            serial_clock_q <= 1'b0;
                            xfer_count     <= xfer_count + 1'b1;
                        end
                    end
                end
                padctl_pkg::LDR_LOAD: begin
                    xfer_count <= xfer_count + 1'b1;
                    case (xfer_count)
                        CNT_W'(0): begin
                            serial_clock_q  <= 1'b1;
                            serial_resetn_q <= 1'b1;
                        end
                        // Load pulse while the clock is held high
                        CNT_W'(1): serial_resetn_q <= 1'b0;
                        CNT_W'(2): serial_resetn_q <= 1'b1;
                        default: begin
                            serial_clock_q <= 1'b0;
                            state_q        <= padctl_pkg::LDR_IDLE;
                        end
                    endcase
                end
                default: state_q <= padctl_pkg::LDR_IDLE;
            endcase
        end
    end

    assign busy_o = (state_q != padctl_pkg::LDR_IDLE);

    always_comb begin
        serial_o.clock  = serial_clock_q;
        serial_o.resetn = serial_resetn_q;
        serial_o.data_1 = staging_1[`PADCTL_CTRL_BITS-1];
        serial_o.data_2 = staging_2[`PADCTL_CTRL_BITS-1];
    end

endmodule

`default_nettype wire

/* logic/padctl_defines.svh */
`ifndef PADCTL_DEFINES_SVH
`define PADCTL_DEFINES_SVH

// Pad counts and word widths
`define PADCTL_NUM_PADS    8
`define PADCTL_CHAIN_PADS  4
`define PADCTL_CTRL_BITS   13
`define PADCTL_PWR_BITS    2

// Upper 24 address bits and register offsets
`define PADCTL_BASE_ADR    24'h230000
`define PADCTL_XFER_OFS    8'h00
`define PADCTL_PWR_OFS     8'h04
`define PADCTL_IODATA_OFS  8'h08
`define PADCTL_IOCFG_OFS   8'h20

// Fields inside a pad word and its reset values
`define PADCTL_OEB_BIT     1
`define PADCTL_INPDIS_BIT  3
`define PADCTL_DEF_BIDIR   13'h1803
`define PADCTL_DEF_INPUT   13'h0403

`endif

/* logic/padctl_pkg.sv */
`default_nettype none
`include "padctl_defines.svh"

package padctl_pkg;

    typedef logic [`PADCTL_CTRL_BITS-1:0] pad_ctrl_t;
    typedef logic [`PADCTL_NUM_PADS-1:0] pad_vec_t;
    typedef logic [`PADCTL_PWR_BITS-1:0] pwr_vec_t;
    typedef pad_ctrl_t [`PADCTL_NUM_PADS-1:0] pad_cfg_arr_t;
    typedef logic [31:0] bus_word_t;

    typedef struct packed {
        bus_word_t   adr;
        bus_word_t   dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    typedef struct packed {
        bus_word_t   dat;
        logic        ack;
    } wb_rsp_t;

    typedef struct packed {
        logic        clock;
        logic        resetn;
        logic        data_1;
        logic        data_2;
    } serial_bus_t;

    typedef enum logic [1:0] {
        LDR_IDLE,
        LDR_START,
        LDR_XBYTE,
        LDR_LOAD
    } loader_state_e;

    // Two pads at each end of the bank come up bidirectional
    function automatic pad_ctrl_t pad_default(input int idx);
        if ((idx < 2) || (idx >= `PADCTL_NUM_PADS - 2)) begin
            return `PADCTL_DEF_BIDIR;
        end
        return `PADCTL_DEF_INPUT;
    endfunction

endpackage

`default_nettype wire

/* logic/padctl_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "padctl_defines.svh"

module padctl_top (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire padctl_pkg::wb_req_t      wb_req_i,
    output wire padctl_pkg::wb_rsp_t      wb_rsp_o,
    input  wire padctl_pkg::pad_vec_t     gpio_in_i,
    output padctl_pkg::pad_vec_t          gpio_out_o,
    output padctl_pkg::pad_vec_t          gpio_oe_o,
    output wire padctl_pkg::pwr_vec_t     pwr_ctrl_o,
    output logic [3:0]                    oenb_state_o,
    output wire padctl_pkg::pad_cfg_arr_t pad_cfg_o,
    output wire padctl_pkg::serial_bus_t  serial_o
);

    wire padctl_pkg::pad_cfg_arr_t  reg_cfg;
    wire padctl_pkg::pad_vec_t      gpio_data;
    wire padctl_pkg::pad_vec_t      chain_out;
    wire                            xfer_start;
    wire                            busy;

    padctl_wb_regs u_regs (
        .clk          (clk),
        .resetn       (resetn),
        .wb_req_i     (wb_req_i),
        .wb_rsp_o     (wb_rsp_o),
        .gpio_in_i    (gpio_in_i),
        .busy_i       (busy),
        .pad_cfg_o    (reg_cfg),
        .gpio_data_o  (gpio_data),
        .pwr_ctrl_o   (pwr_ctrl_o),
        .xfer_start_o (xfer_start)
    );

    pad_serial_loader u_loader (
        .clk          (clk),
        .resetn       (resetn),
        .pad_cfg_i    (reg_cfg),
        .xfer_start_i (xfer_start),
        .busy_o       (busy),
        .serial_o     (serial_o)
    );

    // Chain 1 runs pad 0 up to pad 3, chain 2 runs pad 7 down to pad 4
    for (genvar i = 0; i < `PADCTL_NUM_PADS; i++) begin : g_cell
        logic shift_in;

        if (i == 0) begin : g_head_1
            assign shift_in = serial_o.data_1;
        end else if (i < `PADCTL_CHAIN_PADS) begin : g_link_1
            assign shift_in = chain_out[i-1];
        end else if (i == `PADCTL_NUM_PADS - 1) begin : g_head_2
            assign shift_in = serial_o.data_2;
        end else begin : g_link_2
            assign shift_in = chain_out[i+1];
        end

        pad_cfg_cell #(
            .DEFAULT_CFG (padctl_pkg::pad_default(i))
        ) u_cell (
            .clk             (clk),
            .resetn          (resetn),
            .serial_clock_i  (serial_o.clock),
            .serial_load_n_i (serial_o.resetn),
            .shift_in_i      (shift_in),
            .shift_out_o     (chain_out[i]),
            .cfg_o           (pad_cfg_o[i])
        );
    end

    // Management drives a pad only when its input is disabled
    always_comb begin
        for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
            gpio_oe_o[i] = reg_cfg[i][`PADCTL_INPDIS_BIT];
        end
    end

    assign gpio_out_o = gpio_data & gpio_oe_o;

    assign oenb_state_o = {pad_cfg_o[`PADCTL_NUM_PADS-1][`PADCTL_OEB_BIT],
                           pad_cfg_o[`PADCTL_NUM_PADS-2][`PADCTL_OEB_BIT],
                           pad_cfg_o[1][`PADCTL_OEB_BIT],
                           pad_cfg_o[0][`PADCTL_OEB_BIT]};

endmodule

`default_nettype wire

/* logic/padctl_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "padctl_defines.svh"

module padctl_wb_regs (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire padctl_pkg::wb_req_t      wb_req_i,
    output padctl_pkg::wb_rsp_t           wb_rsp_o,
    input  wire padctl_pkg::pad_vec_t     gpio_in_i,
    input  wire                           busy_i,
    output padctl_pkg::pad_cfg_arr_t      pad_cfg_o,
    output padctl_pkg::pad_vec_t          gpio_data_o,
    output padctl_pkg::pwr_vec_t          pwr_ctrl_o,
    output logic                          xfer_start_o
);

    logic                      req_hit;
    logic                      req_new;
    logic                      wr_en;
    logic [7:0]                ofs;
    logic                      xfer_sel;
    logic                      pwr_sel;
    logic                      iodata_sel;
    padctl_pkg::pad_vec_t      cfg_sel;
    logic                      selected;
    padctl_pkg::bus_word_t     rdata_pre;
    padctl_pkg::bus_word_t     rdata_q;
    logic                      ack_q;
    padctl_pkg::pad_cfg_arr_t  pad_cfg_q;
    padctl_pkg::pad_vec_t      gpio_data_q;
    padctl_pkg::pwr_vec_t      pwr_q;
    logic                      xfer_start_q;

    // Block select on the upper address bits
    assign req_hit = wb_req_i.cyc & wb_req_i.stb
                   & (wb_req_i.adr[31:8] == `PADCTL_BASE_ADR);

    // Only the first cycle of a request is acted on
    assign req_new = req_hit & ~ack_q;
    assign wr_en   = req_new & wb_req_i.we & wb_req_i.sel[0];

    assign ofs        = wb_req_i.adr[7:0];
    assign xfer_sel   = (ofs == `PADCTL_XFER_OFS);
    assign pwr_sel    = (ofs == `PADCTL_PWR_OFS);
    assign iodata_sel = (ofs == `PADCTL_IODATA_OFS);

    // One config word per pad, four bytes apart
    always_comb begin
        for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
            cfg_sel[i] = (ofs == 8'(`PADCTL_IOCFG_OFS + 4 * i));
        end
    end

    assign selected = xfer_sel | pwr_sel | iodata_sel | (|cfg_sel);

    // Read word
    always_comb begin
        rdata_pre = '0;
        if (xfer_sel) begin
            rdata_pre = padctl_pkg::bus_word_t'(busy_i);
        end else if (pwr_sel) begin
            rdata_pre = padctl_pkg::bus_word_t'(pwr_q);
        end else if (iodata_sel) begin
            rdata_pre = padctl_pkg::bus_word_t'(gpio_in_i);
        end else begin
            for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
                if (cfg_sel[i]) begin
                    rdata_pre = padctl_pkg::bus_word_t'(pad_cfg_q[i]);
                end
            end
        end
    end

    // Acknowledge and read data
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q <= req_new;
            // Undecoded offsets keep the last read word
            if (req_new && selected) begin
                rdata_q <= rdata_pre;
            end
        end
    end

    // Writable registers
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
                pad_cfg_q[i] <= padctl_pkg::pad_default(i);
            end
            gpio_data_q  <= '0;
            pwr_q        <= '0;
            xfer_start_q <= 1'b0;
        end else begin
            // Transfer bit clears itself after one cycle
            xfer_start_q <= wr_en & xfer_sel & wb_req_i.dat[0];
            if (wr_en && pwr_sel) begin
                pwr_q <= wb_req_i.dat[`PADCTL_PWR_BITS-1:0];
            end
            if (wr_en && iodata_sel) begin
                gpio_data_q <= wb_req_i.dat[`PADCTL_NUM_PADS-1:0];
            end
            for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
                if (wr_en && cfg_sel[i]) begin
                    pad_cfg_q[i] <= wb_req_i.dat[`PADCTL_CTRL_BITS-1:0];
                end
            end
        end
    end

    always_comb begin
        wb_rsp_o.dat = rdata_q;
        wb_rsp_o.ack = ack_q;
    end

    assign pad_cfg_o    = pad_cfg_q;
    assign gpio_data_o  = gpio_data_q;
    assign pwr_ctrl_o   = pwr_q;
    assign xfer_start_o = xfer_start_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the padctl testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -f verilog.f --top-module padctl_tb -o padctl_sim \
    > build.log 2>&1 \
    && ./obj_dir/padctl_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

/* sim/padctl_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "padctl_defines.svh"

module padctl_tb;

    localparam int TIMEOUT_CYCLES = 6 * 300 + 3 * 150;

    logic                      clk;
    logic                      resetn;
    padctl_pkg::wb_req_t       wb_req;
    padctl_pkg::wb_rsp_t       wb_rsp;
    padctl_pkg::pad_vec_t      gpio_in;
    padctl_pkg::pad_vec_t      gpio_out;
    padctl_pkg::pad_vec_t      gpio_oe;
    padctl_pkg::pwr_vec_t      pwr_ctrl;
    logic [3:0]                oenb_state;
    padctl_pkg::pad_cfg_arr_t  pad_cfg;
    padctl_pkg::serial_bus_t   serial;
    padctl_pkg::pad_ctrl_t     cfg_words [`PADCTL_NUM_PADS];
    padctl_pkg::bus_word_t     seed;
    logic serial_clock_d = 1'b0;
    logic serial_resetn_d = 1'b0;
    int serial_rises = 0;
    int serial_loads = 0;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_bad = 0;

    padctl_top dut (
        .clk          (clk),
        .resetn       (resetn),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .gpio_in_i    (gpio_in),
        .gpio_out_o   (gpio_out),
        .gpio_oe_o    (gpio_oe),
        .pwr_ctrl_o   (pwr_ctrl),
        .oenb_state_o (oenb_state),
        .pad_cfg_o    (pad_cfg),
        .serial_o     (serial)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // Serial clock rises and load pulses, sampled in the clk domain like the cells
    always @(posedge clk) begin
        serial_clock_d  <= serial.clock;
        serial_resetn_d <= serial.resetn;
        if (serial.clock && !serial_clock_d) begin
            serial_rises <= serial_rises + 1;
        end
        if (!serial.resetn && serial_resetn_d) begin
            serial_loads <= serial_loads + 1;
        end
    end

    function automatic padctl_pkg::bus_word_t reg_adr(input logic [7:0] ofs);
        return {`PADCTL_BASE_ADR, ofs};
    endfunction

    function automatic padctl_pkg::bus_word_t cfg_adr(input int pad);
        return {`PADCTL_BASE_ADR, 8'(`PADCTL_IOCFG_OFS + 4 * pad)};
    endfunction

    // Pads 0, 1, 6 and 7 come up bidirectional
    function automatic padctl_pkg::pad_ctrl_t reset_word(input int pad);
        if (pad == 0 || pad == 1 || pad == 6 || pad == 7) begin
            return `PADCTL_DEF_BIDIR;
        end
        return `PADCTL_DEF_INPUT;
    endfunction

    task automatic check_word(input string name, input padctl_pkg::bus_word_t got,
                              input padctl_pkg::bus_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_cfg(input string name, input padctl_pkg::pad_ctrl_t got,
                             input padctl_pkg::pad_ctrl_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pads(input string name, input padctl_pkg::pad_vec_t got,
                              input padctl_pkg::pad_vec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pwr(input string name, input padctl_pkg::pwr_vec_t got,
                             input padctl_pkg::pwr_vec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // One classic cycle, then one idle cycle so register outputs settle
    task automatic bus_cycle(input padctl_pkg::bus_word_t adr, input padctl_pkg::bus_word_t dat,
                             input logic we, input logic [3:0] sel,
                             output padctl_pkg::bus_word_t rdata);
        int waited;
        waited = 0;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.sel = sel;
        wb_req.we = we;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        @(posedge clk);
        #1;
        while (!wb_rsp.ack && waited < 8) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!wb_rsp.ack) begin
            errors++;
            $display("no acknowledge for address %h", adr);
        end
        rdata = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic wb_write(input padctl_pkg::bus_word_t adr, input padctl_pkg::bus_word_t dat,
                            input logic [3:0] sel);
        padctl_pkg::bus_word_t unused;
        bus_cycle(adr, dat, 1'b1, sel, unused);
    endtask

    task automatic wb_read(input padctl_pkg::bus_word_t adr, output padctl_pkg::bus_word_t rdata);
        bus_cycle(adr, '0, 1'b0, 4'hf, rdata);
    endtask

    task automatic finish_test(input int num, input string name, input int start_err);
        tests_run++;
        if (errors == start_err) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", num, name, errors - start_err);
        end
    endtask

    task automatic write_random_cfg();
        padctl_pkg::bus_word_t rnd;
        for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
            rnd = $urandom;
            wb_write(cfg_adr(i), rnd, 4'hf);
            cfg_words[i] = rnd[`PADCTL_CTRL_BITS-1:0];
        end
    endtask

    // Idle serial bus has the clock low and the load released
    task automatic serial_bus_idle();
        check_word("serial_o.clock", padctl_pkg::bus_word_t'(serial.clock), 32'h0);
        check_word("serial_o.resetn", padctl_pkg::bus_word_t'(serial.resetn), 32'h1);
    endtask

    // Applied words and the OEB bits of pads 0, 1, 6, 7
    task automatic check_applied_cfg();
        padctl_pkg::pad_vec_t exp_oenb;
        for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
            check_cfg($sformatf("pad_cfg_o[%0d]", i), pad_cfg[i], cfg_words[i]);
        end
        exp_oenb = padctl_pkg::pad_vec_t'({cfg_words[7][`PADCTL_OEB_BIT],
                                           cfg_words[6][`PADCTL_OEB_BIT],
                                           cfg_words[1][`PADCTL_OEB_BIT],
                                           cfg_words[0][`PADCTL_OEB_BIT]});
        check_pads("oenb_state_o", padctl_pkg::pad_vec_t'(oenb_state), exp_oenb);
    endtask

    task automatic run_transfer();
        padctl_pkg::bus_word_t rd;
        int polls;
        int rises_start;
        int loads_start;
        polls = 0;
        rises_start = serial_rises;
        loads_start = serial_loads;
        wb_write(reg_adr(`PADCTL_XFER_OFS), 32'h1, 4'hf);
        wb_read(reg_adr(`PADCTL_XFER_OFS), rd);
        check_word("xfer while busy", rd, 32'h1);
        while (rd[0] && polls < 100) begin
            wb_read(reg_adr(`PADCTL_XFER_OFS), rd);
            polls++;
        end
        if (rd[0]) begin
            errors++;
            $display("transfer still busy after %0d polls", polls);
        end
        check_word("xfer when done", rd, 32'h0);
        // One serial clock per bit of every pad word on a chain, then one load
        check_word("serial clock rises", padctl_pkg::bus_word_t'(serial_rises - rises_start),
                   padctl_pkg::bus_word_t'(`PADCTL_CHAIN_PADS * `PADCTL_CTRL_BITS));
        check_word("serial load pulses", padctl_pkg::bus_word_t'(serial_loads - loads_start),
                   32'h1);
        serial_bus_idle();
    endtask

    task automatic reset_defaults();
        padctl_pkg::bus_word_t rd;
        int start_err;
        start_err = errors;
        for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
            wb_read(cfg_adr(i), rd);
            check_word($sformatf("iocfg[%0d]", i), rd, padctl_pkg::bus_word_t'(reset_word(i)));
            check_cfg($sformatf("pad_cfg_o[%0d]", i), pad_cfg[i], reset_word(i));
        end
        check_pads("oenb_state_o", padctl_pkg::pad_vec_t'(oenb_state), 8'h0f);
        wb_read(reg_adr(`PADCTL_XFER_OFS), rd);
        check_word("xfer", rd, 32'h0);
        serial_bus_idle();
        finish_test(1, "reset defaults", start_err);
    endtask

    task automatic bus_protocol();
        padctl_pkg::bus_word_t rd;
        int start_err;
        logic seen;
        start_err = errors;
        seen = 1'b0;
        wb_req.adr = reg_adr(`PADCTL_XFER_OFS);
        wb_req.sel = 4'hf;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        @(posedge clk);
        #1;
        if (!wb_rsp.ack) begin
            errors++;
            $display("acknowledge missing one cycle after the strobe");
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        @(posedge clk);
        #1;
        if (wb_rsp.ack) begin
            errors++;
            $display("acknowledge lasted more than one cycle");
        end
        // Same offset under a foreign base address
        wb_req.adr = {24'h240000, 8'h20};
        wb_req.dat = 32'h0000_1fff;
        wb_req.we = 1'b1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #1;
            seen = seen | wb_rsp.ack;
        end
        if (seen) begin
            errors++;
            $display("request to another base address was acknowledged");
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we = 1'b0;
        @(posedge clk);
        #1;
        wb_read(cfg_adr(0), rd);
        check_word("iocfg[0]", rd, padctl_pkg::bus_word_t'(reset_word(0)));
        finish_test(2, "bus protocol", start_err);
    endtask

    task automatic register_writes();
        padctl_pkg::bus_word_t rd;
        padctl_pkg::bus_word_t rnd;
        padctl_pkg::pwr_vec_t exp_pwr;
        int start_err;
        start_err = errors;
        write_random_cfg();
        for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
            wb_read(cfg_adr(i), rd);
            check_word($sformatf("iocfg[%0d]", i), rd, padctl_pkg::bus_word_t'(cfg_words[i]));
        end
        rnd = $urandom;
        exp_pwr = rnd[`PADCTL_PWR_BITS-1:0];
        wb_write(reg_adr(`PADCTL_PWR_OFS), rnd, 4'hf);
        check_pwr("pwr_ctrl_o", pwr_ctrl, exp_pwr);
        wb_read(reg_adr(`PADCTL_PWR_OFS), rd);
        check_word("pwr", rd, padctl_pkg::bus_word_t'(exp_pwr));
        // Select bit 0 low means no write
        wb_write(cfg_adr(2), ~padctl_pkg::bus_word_t'(cfg_words[2]), 4'he);
        wb_read(cfg_adr(2), rd);
        check_word("iocfg[2] after masked write", rd, padctl_pkg::bus_word_t'(cfg_words[2]));
        wb_write(reg_adr(`PADCTL_PWR_OFS), padctl_pkg::bus_word_t'(~exp_pwr), 4'he);
        check_pwr("pwr_ctrl_o after masked write", pwr_ctrl, exp_pwr);
        finish_test(3, "register writes", start_err);
    endtask

    task automatic gpio_data_paths();
        padctl_pkg::bus_word_t rd;
        padctl_pkg::bus_word_t data;
        padctl_pkg::pad_vec_t exp_oe;
        int start_err;
        start_err = errors;
        data = $urandom;
        gpio_in = data[`PADCTL_NUM_PADS-1:0];
        wb_read(reg_adr(`PADCTL_IODATA_OFS), rd);
        check_word("iodata", rd, padctl_pkg::bus_word_t'(gpio_in));
        data = $urandom;
        wb_write(reg_adr(`PADCTL_IODATA_OFS), data, 4'hf);
        for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
            exp_oe[i] = cfg_words[i][`PADCTL_INPDIS_BIT];
        end
        check_pads("gpio_oe_o", gpio_oe, exp_oe);
        check_pads("gpio_out_o", gpio_out, data[`PADCTL_NUM_PADS-1:0] & exp_oe);
        finish_test(4, "gpio data", start_err);
    endtask

    task automatic config_transfer();
        int start_err;
        start_err = errors;
        // Cells still hold their defaults before the transfer
        for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
            check_cfg($sformatf("pad_cfg_o[%0d] before", i), pad_cfg[i], reset_word(i));
        end
        run_transfer();
        check_applied_cfg();
        finish_test(5, "configuration transfer", start_err);
    endtask

    task automatic repeat_transfer();
        int start_err;
        padctl_pkg::pad_ctrl_t old_words [`PADCTL_NUM_PADS];
        start_err = errors;
        old_words = cfg_words;
        write_random_cfg();
        for (int i = 0; i < `PADCTL_NUM_PADS; i++) begin
            check_cfg($sformatf("pad_cfg_o[%0d] before", i), pad_cfg[i], old_words[i]);
        end
        run_transfer();
        check_applied_cfg();
        finish_test(6, "repeated transfer", start_err);
    endtask

    initial begin
        seed = $urandom(32'hf582);
        clk = 1'b0;
        resetn = 1'b0;
        wb_req = '0;
        gpio_in = '0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
        reset_defaults();
        bus_protocol();
        register_writes();
        gpio_data_paths();
        config_transfer();
        repeat_transfer();
        $display("%0d tests run, %0d with errors, %0d checks, %0d mismatches",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/padctl_pkg.sv
logic/pad_cfg_cell.sv
logic/padctl_wb_regs.sv
logic/pad_serial_loader.sv
logic/padctl_top.sv
sim/padctl_tb.sv
